//--- include/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path width
`define XLEN 32

// byte address bits used on the RAM bus, 0x0 to 0x1FFFF
`define RAM_AW 17

// first instruction address
`define RESET_PC 32'h0000_0000

// bytes moved per arbiter word
`define MC_BYTES 4

// register file address width and the register shown on the debug port
`define REG_AW 5
`define DBG_REG 10

`endif

//--- logic/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    // one instruction word, read through whichever format fits
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
        s_view_t s_view;
    } inst_u;

    // addr is the byte address of an aligned word
    typedef struct packed {
        logic               valid;
        logic               we;
        logic [`RAM_AW-1:0] addr;
        logic [`XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic               valid;
        logic               we;
        logic [`RAM_AW-1:0] addr;
        logic [`XLEN-1:0]   wdata;
    } ls_cmd_t;

endpackage

//--- logic/regfile.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regfile (
    input  logic              clk_in,
    input  logic              rst_i,
    input  logic              rdy_i,
    input  logic [`REG_AW-1:0] raddr1_i,
    input  logic [`REG_AW-1:0] raddr2_i,
    output logic [`XLEN-1:0]  rdata1_o,
    output logic [`XLEN-1:0]  rdata2_o,
    input  logic              we_i,
    input  logic [`REG_AW-1:0] waddr_i,
    input  logic [`XLEN-1:0]  wdata_i,
    output logic [`XLEN-1:0]  dbg_o
);

    localparam int NREGS = 1 << `REG_AW;

    logic [`XLEN-1:0] regs [NREGS];

    // x0 is cleared by reset and never written afterwards
    always_ff @(posedge clk_in) begin
        if (rst_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy_i && we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];
    assign dbg_o    = regs[`DBG_REG];

endmodule

//--- logic/mem_control.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module mem_control import cpu_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_i,
    input  logic        rdy_i,
    input  mem_req_t    if_req_i,
    output logic        if_ready_o,
    output mem_rsp_t    if_rsp_o,
    input  mem_req_t    ls_req_i,
    output logic        ls_ready_o,
    output mem_rsp_t    ls_rsp_o,
    input  logic [7:0]  mem_din_i,
    output logic [7:0]  mem_dout_o,
    output logic [31:0] mem_a_o,
    output logic        mem_wr_o
);

    logic               live_q;
    logic               active_q;
    logic               owner_ls_q;
    logic               prio_ls_q;
    logic               wr_q;
    logic               rsp_valid_q;
    logic [2:0]         phase_q;
    logic [`RAM_AW-1:0] addr_q;
    logic [`XLEN-1:0]   data_q;
    logic [7:0]         dout_q;
    logic               grant_if;
    logic               grant_ls;
    mem_req_t           sel_req;

    // the port without priority backs off while the other one is waiting
    assign if_ready_o = live_q && !active_q && !(ls_req_i.valid && prio_ls_q);
    assign ls_ready_o = live_q && !active_q && !(if_req_i.valid && !prio_ls_q);
    assign grant_if   = if_req_i.valid && if_ready_o;
    assign grant_ls   = ls_req_i.valid && ls_ready_o;
    assign sel_req    = grant_ls ? ls_req_i : if_req_i;

    always_ff @(posedge clk_in) begin
        if (rst_i) begin
            live_q      <= 1'b0;
            active_q    <= 1'b0;
            owner_ls_q  <= 1'b0;
            prio_ls_q   <= 1'b1;
            wr_q        <= 1'b0;
            rsp_valid_q <= 1'b0;
            phase_q     <= '0;
        end else if (rdy_i) begin
            live_q      <= 1'b1;
            rsp_valid_q <= 1'b0;
            if (grant_if || grant_ls) begin
                active_q   <= 1'b1;
                owner_ls_q <= grant_ls;
                // the loser of this grant wins the next tie
                prio_ls_q  <= grant_if;
                phase_q    <= '0;
                addr_q     <= sel_req.addr;
                wr_q       <= sel_req.we;
                dout_q     <= sel_req.wdata[7:0];
                data_q     <= sel_req.wdata >> 8;
            end else if (active_q) begin
                phase_q <= phase_q + 3'd1;
                if (wr_q) begin
                    // byte 0 went out at acceptance and one more follows each cycle
                    addr_q <= addr_q + 1'b1;
                    dout_q <= data_q[7:0];
                    data_q <= data_q >> 8;
                    if (phase_q == `MC_BYTES - 1) begin
                        wr_q        <= 1'b0;
                        active_q    <= 1'b0;
                        rsp_valid_q <= 1'b1;
                    end
                end else begin
                    // next address goes out while the previous byte is in flight
                    if (phase_q < `MC_BYTES - 1) begin
                        addr_q <= addr_q + 1'b1;
                    end
                    if (phase_q != 3'd0) begin
                        data_q <= {mem_din_i, data_q[`XLEN-1:8]};
                    end
                    if (phase_q == `MC_BYTES) begin
                        active_q    <= 1'b0;
                        rsp_valid_q <= 1'b1;
                    end
                end
            end
        end
    end

    assign mem_a_o    = {{(32 - `RAM_AW){1'b0}}, addr_q};
    assign mem_dout_o = dout_q;
    // RAM must not see a write strobe while the core is paused
    assign mem_wr_o   = wr_q && rdy_i;

    assign if_rsp_o.valid = rsp_valid_q && !owner_ls_q;
    assign if_rsp_o.rdata = data_q;
    assign ls_rsp_o.valid = rsp_valid_q && owner_ls_q;
    assign ls_rsp_o.rdata = data_q;

    // write bytes leave in address order within an accepted transfer
    assert property (@(posedge clk_in) disable iff (rst_i)
        mem_wr_o |-> (active_q && addr_q[1:0] == phase_q[1:0]));

    // a requester keeps its request low until its response has arrived
    assert property (@(posedge clk_in) disable iff (rst_i)
        rsp_valid_q |-> !(owner_ls_q ? ls_req_i.valid : if_req_i.valid));

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_unit import cpu_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_i,
    input  logic             rdy_i,
    output mem_req_t         req_o,
    input  logic             req_ready_i,
    input  mem_rsp_t         rsp_i,
    output logic             inst_valid_o,
    output inst_u            inst_o,
    output logic [`XLEN-1:0] pc_o,
    input  logic             inst_ready_i,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] next_pc_i
);

    logic [`XLEN-1:0] pc_q;
    logic             req_q;
    logic             wait_q;
    logic             hold_q;
    inst_u            inst_q;

    always_ff @(posedge clk_in) begin
        if (rst_i) begin
            pc_q   <= `RESET_PC;
            req_q  <= 1'b1;
            wait_q <= 1'b0;
            hold_q <= 1'b0;
        end else if (rdy_i) begin
            if (req_q && req_ready_i) begin
                req_q  <= 1'b0;
                wait_q <= 1'b1;
            end
            if (wait_q && rsp_i.valid) begin
                wait_q <= 1'b0;
                hold_q <= 1'b1;
                inst_q <= rsp_i.rdata;
            end
            if (hold_q && inst_ready_i) begin
                hold_q <= 1'b0;
            end
            // no fetch until the core says where to go
            if (redirect_i) begin
                pc_q  <= next_pc_i;
                req_q <= 1'b1;
            end
        end
    end

    assign req_o.valid  = req_q;
    assign req_o.we     = 1'b0;
    assign req_o.addr   = pc_q[`RAM_AW-1:0];
    assign req_o.wdata  = '0;
    assign inst_valid_o = hold_q;
    assign inst_o       = inst_q;
    assign pc_o         = pc_q;

    // redirect targets from the core keep word alignment
    assert property (@(posedge clk_in) disable iff (rst_i) pc_q[1:0] == 2'b00);

endmodule

//--- logic/load_store_unit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module load_store_unit import cpu_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_i,
    input  logic             rdy_i,
    input  ls_cmd_t          cmd_i,
    output logic             done_o,
    output logic [`XLEN-1:0] load_data_o,
    output mem_req_t         req_o,
    input  logic             req_ready_i,
    input  mem_rsp_t         rsp_i
);

    mem_req_t         req_q;
    logic             wait_q;
    logic             done_q;
    logic [`XLEN-1:0] data_q;

    always_ff @(posedge clk_in) begin
        if (rst_i) begin
            req_q.valid <= 1'b0;
            wait_q      <= 1'b0;
            done_q      <= 1'b0;
        end else if (rdy_i) begin
            done_q <= 1'b0;
            if (cmd_i.valid) begin
                req_q.valid <= 1'b1;
                req_q.we    <= cmd_i.we;
                req_q.addr  <= cmd_i.addr;
                req_q.wdata <= cmd_i.wdata;
            end
            if (req_q.valid && req_ready_i) begin
                req_q.valid <= 1'b0;
                wait_q      <= 1'b1;
            end
            // store responses carry no data, the pulse still marks completion
            if (wait_q && rsp_i.valid) begin
                wait_q <= 1'b0;
                done_q <= 1'b1;
                data_q <= rsp_i.rdata;
            end
        end
    end

    assign req_o       = req_q;
    assign done_o      = done_q;
    assign load_data_o = data_q;

    // the core waits for done before it can send another command
    assert property (@(posedge clk_in) disable iff (rst_i)
        cmd_i.valid |-> !(req_q.valid || wait_q));

endmodule

//--- logic/exec_core.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module exec_core import cpu_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_i,
    input  logic               rdy_i,
    input  logic               inst_valid_i,
    input  inst_u              inst_i,
    input  logic [`XLEN-1:0]   pc_i,
    output logic               inst_ready_o,
    output logic               redirect_o,
    output logic [`XLEN-1:0]   next_pc_o,
    output logic [`REG_AW-1:0] rf_raddr1_o,
    output logic [`REG_AW-1:0] rf_raddr2_o,
    input  logic [`XLEN-1:0]   rf_rdata1_i,
    input  logic [`XLEN-1:0]   rf_rdata2_i,
    output logic               rf_we_o,
    output logic [`REG_AW-1:0] rf_waddr_o,
    output logic [`XLEN-1:0]   rf_wdata_o,
    output ls_cmd_t            ls_cmd_o,
    input  logic               ls_done_i,
    input  logic [`XLEN-1:0]   ls_data_i
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_EXEC = 2'd1;
    localparam logic [1:0] S_MEM  = 2'd2;

    logic [1:0]       state_q;
    inst_u            inst_q;
    logic [`XLEN-1:0] pc_q;
    opcode_e          opc;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] i_imm, s_imm, b_imm, j_imm, u_imm;
    logic [`XLEN-1:0] op_b, alu_res, wb_data, next_pc, ls_addr;
    logic             wb_en, mem_op, taken;

    always_ff @(posedge clk_in) begin
        if (rst_i) begin
            state_q <= S_IDLE;
        end else if (rdy_i) begin
            case (state_q)
                S_IDLE: if (inst_valid_i) begin
                    inst_q  <= inst_i;
                    pc_q    <= pc_i;
                    state_q <= S_EXEC;
                end
                S_EXEC: state_q <= mem_op ? S_MEM : S_IDLE;
                S_MEM: if (ls_done_i) begin
                    state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign opc   = opcode_e'(inst_q.r_view.opcode);
    assign i_imm = {{20{inst_q.i_view.imm12[11]}}, inst_q.i_view.imm12};
    assign s_imm = {{20{inst_q.s_view.imm_hi[6]}}, inst_q.s_view.imm_hi, inst_q.s_view.imm_lo};
    // B and J immediates are scattered over the S and R fields
    assign b_imm = {{19{inst_q.s_view.imm_hi[6]}}, inst_q.s_view.imm_hi[6],
                    inst_q.s_view.imm_lo[0], inst_q.s_view.imm_hi[5:0],
                    inst_q.s_view.imm_lo[4:1], 1'b0};
    assign j_imm = {{11{inst_q.r_view.funct7[6]}}, inst_q.r_view.funct7[6],
                    inst_q.r_view.rs1, inst_q.r_view.funct3, inst_q.r_view.rs2[0],
                    inst_q.r_view.funct7[5:0], inst_q.r_view.rs2[4:1], 1'b0};
    assign u_imm = {inst_q.r_view.funct7, inst_q.r_view.rs2, inst_q.r_view.rs1,
                    inst_q.r_view.funct3, 12'b0};

    always_comb begin
        case (inst_q.r_view.funct3)
            3'b100:  alu_op = ALU_XOR;
            3'b110:  alu_op = ALU_OR;
            3'b111:  alu_op = ALU_AND;
            // funct7 bit 5 means SUB only for register-register ops
            default: alu_op = (opc == OPC_OP && inst_q.r_view.funct7[5]) ? ALU_SUB : ALU_ADD;
        endcase
    end

    assign op_b = (opc == OPC_OP) ? rf_rdata2_i : i_imm;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = rf_rdata1_i - op_b;
            ALU_AND: alu_res = rf_rdata1_i & op_b;
            ALU_OR:  alu_res = rf_rdata1_i | op_b;
            ALU_XOR: alu_res = rf_rdata1_i ^ op_b;
            default: alu_res = rf_rdata1_i + op_b;
        endcase
    end

    // BEQ on funct3 000, BNE on 001
    assign taken = (inst_q.r_view.funct3[2:1] == 2'b00) &&
                   (inst_q.r_view.funct3[0] ^ (rf_rdata1_i == rf_rdata2_i));

    always_comb begin
        wb_en   = 1'b0;
        mem_op  = 1'b0;
        wb_data = alu_res;
        next_pc = pc_q + 32'd4;
        case (opc)
            OPC_LUI: begin
                wb_en   = 1'b1;
                wb_data = u_imm;
            end
            OPC_OP_IMM, OPC_OP: wb_en = 1'b1;
            OPC_JAL: begin
                wb_en   = 1'b1;
                wb_data = pc_q + 32'd4;
                next_pc = pc_q + j_imm;
            end
            OPC_BRANCH: if (taken) begin
                next_pc = pc_q + b_imm;
            end
            OPC_LOAD, OPC_STORE: mem_op = 1'b1;
            // anything else retires as a no-op
            default: wb_en = 1'b0;
        endcase
    end

    assign ls_addr = rf_rdata1_i + ((opc == OPC_STORE) ? s_imm : i_imm);

    assign ls_cmd_o.valid = (state_q == S_EXEC) && mem_op;
    assign ls_cmd_o.we    = (opc == OPC_STORE);
    assign ls_cmd_o.addr  = ls_addr[`RAM_AW-1:0];
    assign ls_cmd_o.wdata = rf_rdata2_i;

    assign inst_ready_o = (state_q == S_IDLE);
    assign rf_raddr1_o  = inst_q.r_view.rs1;
    assign rf_raddr2_o  = inst_q.r_view.rs2;
    assign rf_waddr_o   = inst_q.r_view.rd;
    assign rf_we_o      = ((state_q == S_EXEC) && wb_en) ||
                          ((state_q == S_MEM) && ls_done_i && opc == OPC_LOAD);
    assign rf_wdata_o   = (state_q == S_MEM) ? ls_data_i : wb_data;
    // retire point, the fetch unit moves on from here
    assign redirect_o   = ((state_q == S_EXEC) && !mem_op) ||
                          ((state_q == S_MEM) && ls_done_i);
    assign next_pc_o    = next_pc;

endmodule

//--- logic/cpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu import cpu_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_i,
    input  logic        rdy_i,
    input  logic [7:0]  mem_din_i,
    output logic [7:0]  mem_dout_o,
    output logic [31:0] mem_a_o,
    output logic        mem_wr_o,
    output logic [31:0] dbgreg_o
);

    // fetch and load/store ports of the arbiter
    mem_req_t           if_req, ls_req;
    mem_rsp_t           if_rsp, ls_rsp;
    logic               if_ready, ls_ready;

    // fetch to core
    logic               inst_valid, inst_ready;
    inst_u              inst;
    logic [`XLEN-1:0]   pc, next_pc;
    logic               redirect;

    // core to register file and load/store unit
    logic [`REG_AW-1:0] raddr1, raddr2, waddr;
    logic [`XLEN-1:0]   rdata1, rdata2, wdata;
    logic               rf_we;
    ls_cmd_t            ls_cmd;
    logic               ls_done;
    logic [`XLEN-1:0]   ls_data;

    fetch_unit fetch_unit0 (
        .clk_in(clk_in), .rst_i(rst_i), .rdy_i(rdy_i),
        .req_o(if_req), .req_ready_i(if_ready), .rsp_i(if_rsp),
        .inst_valid_o(inst_valid), .inst_o(inst), .pc_o(pc),
        .inst_ready_i(inst_ready), .redirect_i(redirect), .next_pc_i(next_pc)
    );

    load_store_unit load_store_unit0 (
        .clk_in(clk_in), .rst_i(rst_i), .rdy_i(rdy_i),
        .cmd_i(ls_cmd), .done_o(ls_done), .load_data_o(ls_data),
        .req_o(ls_req), .req_ready_i(ls_ready), .rsp_i(ls_rsp)
    );

    mem_control mem_control0 (
        .clk_in(clk_in), .rst_i(rst_i), .rdy_i(rdy_i),
        .if_req_i(if_req), .if_ready_o(if_ready), .if_rsp_o(if_rsp),
        .ls_req_i(ls_req), .ls_ready_o(ls_ready), .ls_rsp_o(ls_rsp),
        .mem_din_i(mem_din_i), .mem_dout_o(mem_dout_o),
        .mem_a_o(mem_a_o), .mem_wr_o(mem_wr_o)
    );

    regfile regfile0 (
        .clk_in(clk_in), .rst_i(rst_i), .rdy_i(rdy_i),
        .raddr1_i(raddr1), .raddr2_i(raddr2), .rdata1_o(rdata1), .rdata2_o(rdata2),
        .we_i(rf_we), .waddr_i(waddr), .wdata_i(wdata), .dbg_o(dbgreg_o)
    );

    exec_core exec_core0 (
        .clk_in(clk_in), .rst_i(rst_i), .rdy_i(rdy_i),
        .inst_valid_i(inst_valid), .inst_i(inst), .pc_i(pc), .inst_ready_o(inst_ready),
        .redirect_o(redirect), .next_pc_o(next_pc),
        .rf_raddr1_o(raddr1), .rf_raddr2_o(raddr2),
        .rf_rdata1_i(rdata1), .rf_rdata2_i(rdata2),
        .rf_we_o(rf_we), .rf_waddr_o(waddr), .rf_wdata_o(wdata),
        .ls_cmd_o(ls_cmd), .ls_done_i(ls_done), .ls_data_i(ls_data)
    );

endmodule

//--- sim/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu import cpu_pkg::*; ();

    localparam int RAM_BYTES = 1 << `RAM_AW;

    logic               clk_in = 1'b0;
    logic               rst_i;
    logic               rdy_i;
    logic [7:0]         mem_din_i;
    logic [7:0]         mem_dout_o;
    logic [31:0]        mem_a_o;
    logic               mem_wr_o;
    logic [31:0]        dbgreg_o;

    logic [7:0]         ram [RAM_BYTES];
    logic [7:0]         ref_ram [RAM_BYTES];
    logic [`XLEN-1:0]   ref_regs [32];
    logic [`RAM_AW-1:0] rd_addr;
    logic [`XLEN-1:0]   wr_word;
    logic [1:0]         wr_byte;
    logic [15:0]        lfsr;
    logic               stall_en;
    mem_req_t           exp_q [$];
    mem_req_t           obs_q [$];
    int                 pc_gen, slot, n_checked, n_exec, cycles, limit;
    int                 seg_load, seg_branch, seg_final;
    int                 val_errs, other_errs;

    cpu cpu_inst (
        .clk_in(clk_in), .rst_i(rst_i), .rdy_i(rdy_i),
        .mem_din_i(mem_din_i), .mem_dout_o(mem_dout_o),
        .mem_a_o(mem_a_o), .mem_wr_o(mem_wr_o), .dbgreg_o(dbgreg_o)
    );

    initial begin
        forever begin
            #10 clk_in = ~clk_in;
        end
    end

    // Galois LFSR on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
            v    = {v[30:0], b};
        end
        return v;
    endfunction

    // any register but x1, which holds the data base
    function automatic logic [4:0] pick_dest();
        logic [4:0] r;
        r = 5'(take_bits(5));
        return (r == 5'd1) ? 5'd2 : r;
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            ram[pc_gen + i] = w[8*i +: 8];
        end
        pc_gen += 4;
    endtask

    // each store goes to the next word of the data region
    task automatic store_reg(input logic [4:0] rs);
        emit(s_type(12'(slot * 4), rs, 5'd1, 3'b010));
        slot++;
    endtask

    task automatic build_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [3:0]  kind;
        pc_gen = `RESET_PC;
        slot   = 0;
        emit({20'h00010, 5'd1, OPC_LUI});
        for (int n = 0; n < 24; n++) begin
            rd   = pick_dest();
            rs1  = 5'(take_bits(5));
            rs2  = 5'(take_bits(5));
            imm  = 12'(take_bits(12));
            kind = 4'(take_bits(4) % 10);
            case (kind)
                4'd0:    emit({20'(take_bits(20)), rd, OPC_LUI});
                4'd1:    emit(i_type(imm, rs1, 3'b000, rd, OPC_OP_IMM));
                4'd2:    emit(i_type(imm, rs1, 3'b111, rd, OPC_OP_IMM));
                4'd3:    emit(i_type(imm, rs1, 3'b110, rd, OPC_OP_IMM));
                4'd4:    emit(i_type(imm, rs1, 3'b100, rd, OPC_OP_IMM));
                4'd5:    emit({7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP});
                4'd6:    emit({7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP});
                4'd7:    emit({7'b0000000, rs2, rs1, 3'b111, rd, OPC_OP});
                4'd8:    emit({7'b0000000, rs2, rs1, 3'b110, rd, OPC_OP});
                default: emit({7'b0000000, rs2, rs1, 3'b100, rd, OPC_OP});
            endcase
            store_reg(rd);
        end
        // a write to x0 must leave it at zero
        emit(i_type(12'h7ff, 5'd3, 3'b000, 5'd0, OPC_OP_IMM));
        store_reg(5'd0);
        seg_load = slot;
        for (int n = 0; n < 6; n++) begin
            rd = pick_dest();
            store_reg(5'(take_bits(5)));
            emit(i_type(12'((slot - 1) * 4), 5'd1, 3'b010, rd, OPC_LOAD));
            store_reg(rd);
        end
        seg_branch = slot;
        // half the branches compare a register with itself
        for (int n = 0; n < 8; n++) begin
            rs1 = 5'(take_bits(5));
            rs2 = take_bits(1) ? rs1 : 5'(take_bits(5));
            emit(b_type(13'd8, rs2, rs1, {2'b00, 1'(take_bits(1))}));
            emit(i_type(12'd1, 5'd11, 3'b000, 5'd11, OPC_OP_IMM));
            store_reg(5'd11);
        end
        for (int n = 0; n < 3; n++) begin
            rd = pick_dest();
            emit(j_type(21'd8, rd));
            emit(i_type(12'd1, 5'd11, 3'b000, 5'd11, OPC_OP_IMM));
            store_reg(rd);
        end
        seg_final = slot;
        emit(i_type(12'(take_bits(12)), 5'd10, 3'b100, 5'd10, OPC_OP_IMM));
        store_reg(5'd10);
        emit(j_type(21'd0, 5'd0));
    endtask

    // instruction set model that returns the number of executed instructions
    function automatic int run_reference();
        logic [`XLEN-1:0]   pc, next, w, a, b, opb, res, addr;
        logic [`XLEN-1:0]   imm_i, imm_s, imm_b, imm_j;
        logic [`RAM_AW-1:0] ma;
        logic               wb, halt;
        mem_req_t           st;
        int                 steps;
        pc    = `RESET_PC;
        steps = 0;
        halt  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        while (!halt && steps < 4096) begin
            ma    = pc[`RAM_AW-1:0];
            w     = {ref_ram[ma + 3], ref_ram[ma + 2], ref_ram[ma + 1], ref_ram[ma]};
            a     = ref_regs[w[19:15]];
            b     = ref_regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            next  = pc + 32'd4;
            wb    = 1'b0;
            res   = '0;
            case (w[6:0])
                OPC_LUI: begin
                    res = {w[31:12], 12'b0};
                    wb  = 1'b1;
                end
                OPC_OP_IMM, OPC_OP: begin
                    opb = (w[6:0] == OPC_OP) ? b : imm_i;
                    case (w[14:12])
                        3'b000:  res = (w[6:0] == OPC_OP && w[30]) ? a - opb : a + opb;
                        3'b100:  res = a ^ opb;
                        3'b110:  res = a | opb;
                        3'b111:  res = a & opb;
                        default: res = a + opb;
                    endcase
                    wb = 1'b1;
                end
                OPC_LOAD: begin
                    ma  = 17'(a + imm_i);
                    res = {ref_ram[ma + 3], ref_ram[ma + 2], ref_ram[ma + 1], ref_ram[ma]};
                    wb  = 1'b1;
                end
                OPC_STORE: begin
                    addr = a + imm_s;
                    ma   = addr[`RAM_AW-1:0];
                    for (int i = 0; i < 4; i++) begin
                        ref_ram[ma + 17'(i)] = b[8*i +: 8];
                    end
                    st.valid = 1'b1;
                    st.we    = 1'b1;
                    st.addr  = ma;
                    st.wdata = b;
                    exp_q.push_back(st);
                end
                OPC_BRANCH: begin
                    if (w[14:13] == 2'b00 && ((w[12] == 1'b0) == (a == b))) begin
                        next = pc + imm_b;
                    end
                end
                OPC_JAL: begin
                    res  = pc + 32'd4;
                    wb   = 1'b1;
                    next = pc + imm_j;
                    halt = (imm_j == '0);
                end
                default: wb = 1'b0;
            endcase
            if (wb && w[11:7] != 5'd0) begin
                ref_regs[w[11:7]] = res;
            end
            pc = next;
            steps++;
        end
        return steps;
    endfunction

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp, act);
        if (act !== exp) begin
            $display("ERR %s expected %08h actual %08h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_store(input string name, input mem_req_t exp, act);
        if (act.addr !== exp.addr || act.wdata !== exp.wdata) begin
            $display("ERR %s expected %05h:%08h actual %05h:%08h",
                     name, exp.addr, exp.wdata, act.addr, act.wdata);
            val_errs++;
        end
    endtask

    function automatic string store_name(input int idx);
        string seg;
        if (idx >= seg_final) begin
            seg = "final";
        end else if (idx >= seg_branch) begin
            seg = "branch";
        end else if (idx >= seg_load) begin
            seg = "load";
        end else begin
            seg = "alu";
        end
        return $sformatf("%s store %0d", seg, idx);
    endfunction

    // a written byte lands on the edge where the strobe is seen
    always @(posedge clk_in) begin : ram_write
        mem_req_t st;
        if (!rst_i && mem_wr_o === 1'b1) begin
            if (!rdy_i) begin
                $display("write strobe to %05h seen while rdy_i is low", mem_a_o[16:0]);
                other_errs++;
            end else begin
                if (mem_a_o[1:0] != wr_byte) begin
                    $display("byte write to %05h arrived out of order", mem_a_o[16:0]);
                    other_errs++;
                end
                ram[mem_a_o[`RAM_AW-1:0]] = mem_dout_o;
                wr_word[8*mem_a_o[1:0] +: 8] = mem_dout_o;
                wr_byte = mem_a_o[1:0] + 2'd1;
                if (mem_a_o[1:0] == 2'd3) begin
                    st.valid = 1'b1;
                    st.we    = 1'b1;
                    st.addr  = {mem_a_o[`RAM_AW-1:2], 2'b00};
                    st.wdata = wr_word;
                    obs_q.push_back(st);
                    $display("store %05h <= %08h", st.addr, st.wdata);
                end
            end
        end
    end

    // read data shows up two cycles after its address, and a paused bus freezes it
    always @(negedge clk_in) begin
        if (rdy_i) begin
            mem_din_i <= ram[rd_addr];
            rd_addr   <= mem_a_o[`RAM_AW-1:0];
        end
        if (stall_en) begin
            rdy_i <= (take_bits(3) != 32'd0);
        end
    end

    always @(negedge clk_in) begin : compare_stores
        mem_req_t st;
        while (obs_q.size() > 0) begin
            st = obs_q.pop_front();
            if (n_checked < exp_q.size()) begin
                check_store(store_name(n_checked), exp_q[n_checked], st);
            end else begin
                $display("extra store to %05h after the expected stream ended", st.addr);
                other_errs++;
            end
            n_checked++;
        end
    end

    initial begin
        rst_i      = 1'b1;
        rdy_i      = 1'b1;
        mem_din_i  = 8'h00;
        stall_en   = 1'b0;
        rd_addr    = '0;
        wr_byte    = 2'd0;
        wr_word    = '0;
        lfsr       = 16'd27257;
        val_errs   = 0;
        other_errs = 0;
        n_checked  = 0;
        cycles     = 0;
        // background fill that depends on every address bit
        for (int a = 0; a < RAM_BYTES; a++) begin
            ram[a] = 8'(a ^ (a >> 8) ^ (a >> 16));
        end
        build_program();
        ref_ram = ram;
        n_exec  = run_reference();
        limit   = n_exec * 40;
        $display("program runs %0d instructions with %0d stores", n_exec, exp_q.size());
        repeat (16) @(negedge clk_in);
        rst_i    <= 1'b0;
        stall_en <= 1'b1;
        while (n_checked < exp_q.size() && cycles < limit) begin
            @(posedge clk_in);
            cycles++;
        end
        if (n_checked < exp_q.size()) begin
            $display("timeout after %0d cycles, %0d of %0d stores seen",
                     cycles, n_checked, exp_q.size());
            other_errs++;
        end
        repeat (8) @(negedge clk_in);
        check_word("x10 on dbgreg", ref_regs[10], dbgreg_o);
        $display("errors: %0d value mismatches, %0d other", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- cpu.f
+incdir+include
logic/cpu_pkg.sv
logic/regfile.sv
logic/mem_control.sv
logic/fetch_unit.sv
logic/load_store_unit.sv
logic/exec_core.sv
logic/cpu.sv
sim/tb_cpu.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f cpu.f
	@out="$$(./obj_dir/Vtb_cpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
